//--- hw/rv_core_pkg.sv
// Core types, opcode and ALU encodings, fixed addresses, control and retire records
package rv_core_pkg;

    ////////////////////////////////////////////////////////////////////
    // Widths with a meaning
    ////////////////////////////////////////////////////////////////////
    typedef logic [31:0] xlen_t;     // Register and ALU data word
    typedef logic [31:0] addr_t;     // Byte address
    typedef logic [31:0] inst_t;     // Raw instruction word
    typedef logic [4:0]  reg_idx_t;  // Register index

    localparam addr_t RESET_ADDR = 32'h0000_0000; // PC after reset
    localparam addr_t INST_BYTES = 32'd4;         // Fixed 32-bit instructions

    // Major opcodes handled by the core
    typedef enum logic [6:0] {
        OP     = 7'b011_0011,
        OP_IMM = 7'b001_0011,
        LUI    = 7'b011_0111,
        AUIPC  = 7'b001_0111,
        LOAD   = 7'b000_0011,
        STORE  = 7'b010_0011,
        BRANCH = 7'b110_0011
    } opcode_e;

    // Single-level ALU select
    typedef enum logic [3:0] {
        ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND,
        PASS_B  // LUI path, operand 2 straight through
    } alu_op_e;

    // Branch tests, same codes as funct3
    typedef enum logic [2:0] {
        BEQ  = 3'b000,
        BNE  = 3'b001,
        BLT  = 3'b100,
        BGE  = 3'b101,
        BLTU = 3'b110,
        BGEU = 3'b111
    } br_cond_e;

    // Operand 1 source
    typedef enum logic [1:0] {
        RS1, ZERO, PC
    } op1_sel_e;

    ////////////////////////////////////////////////////////////////////
    // Bundles
    ////////////////////////////////////////////////////////////////////
    typedef struct packed {
        alu_op_e  alu_op;
        br_cond_e br_cond;
        op1_sel_e op1_sel;
        logic     use_imm;    // Operand 2 is imm, else rs2
        logic     is_branch;
        logic     mem_read;
        logic     mem_write;
        logic     reg_write;
        reg_idx_t rs1;
        reg_idx_t rs2;
        reg_idx_t rd;
        xlen_t    imm;        // Already sign extended and shifted
    } ctrl_t;

    typedef struct packed {
        logic     valid;
        inst_t    inst;
        addr_t    pc;
        addr_t    next_pc;
        reg_idx_t rs1_raddr;
        reg_idx_t rs2_raddr;
        xlen_t    rs1_rdata;
        xlen_t    rs2_rdata;
        reg_idx_t rd_waddr;
        xlen_t    rd_wdata;
    } retire_t;

endpackage

//--- hw/pc_fetch.sv
// Program counter register with sequential or branch next-PC select
module pc_fetch import rv_core_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  i_branch_taken,  // From ALU compare
    input  addr_t i_branch_target, // PC + B-immediate
    output addr_t o_pc,
    output addr_t o_next_pc        // Also reported on retire
);

    addr_t pc_q;

    // Sequential fetch unless a taken branch redirects
    always_comb begin
        if (i_branch_taken) begin
            o_next_pc = i_branch_target;
        end else begin
            o_next_pc = pc_q + INST_BYTES;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_n) begin
            pc_q <= RESET_ADDR; // Reset is active high
        end else begin
            pc_q <= o_next_pc;
        end
    end

    assign o_pc = pc_q; // Drives imem address directly

endmodule

//--- hw/inst_decode.sv
// Opcode and funct decode into the control bundle, with immediate generation
module inst_decode import rv_core_pkg::*; (
    input  inst_t i_inst,
    output ctrl_t o_ctrl
);

    logic [2:0] funct3;
    logic       alt;     // funct7[5], sub or arithmetic shift
    xlen_t      imm_i;
    xlen_t      imm_s;
    xlen_t      imm_b;
    xlen_t      imm_u;

    // funct3 to ALU op, alt picks SUB or SRA
    function automatic alu_op_e funct_alu_op(input logic [2:0] f3, input logic f7_alt);
        case (f3)
            3'b000:  return f7_alt ? SUB : ADD;
            3'b001:  return SLL;
            3'b010:  return SLT;
            3'b011:  return SLTU;
            3'b100:  return XOR;
            3'b101:  return f7_alt ? SRA : SRL;
            3'b110:  return OR;
            default: return AND;
        endcase
    endfunction

    assign funct3 = i_inst[14:12];
    assign alt    = i_inst[30];

    ////////////////////////////////////////////////////////////////////
    // Immediate formats
    ////////////////////////////////////////////////////////////////////
    assign imm_i = {{20{i_inst[31]}}, i_inst[31:20]};
    assign imm_s = {{20{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
    assign imm_b = {{19{i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25],
                    i_inst[11:8], 1'b0};
    assign imm_u = {i_inst[31:12], 12'b0};

    always_comb begin
        // Inactive bundle, computes 0 + 0 and touches nothing
        o_ctrl         = '0;
        o_ctrl.alu_op  = ADD;
        o_ctrl.br_cond = BEQ;
        o_ctrl.op1_sel = ZERO;
        o_ctrl.use_imm = 1'b1;
        o_ctrl.rs1     = i_inst[19:15];
        o_ctrl.rs2     = i_inst[24:20];
        o_ctrl.rd      = i_inst[11:7];

        case (i_inst[6:0])
            OP: begin
                o_ctrl.alu_op    = funct_alu_op(funct3, alt);
                o_ctrl.op1_sel   = RS1;
                o_ctrl.use_imm   = 1'b0;
                o_ctrl.reg_write = 1'b1;
            end
            OP_IMM: begin
                // No subi, alt only matters for right shifts
                o_ctrl.alu_op    = funct_alu_op(funct3, alt && (funct3 == 3'b101));
                o_ctrl.op1_sel   = RS1;
                o_ctrl.imm       = imm_i;   // Shamt sits in low 5 bits
                o_ctrl.reg_write = 1'b1;
            end
            LUI: begin
                o_ctrl.alu_op    = PASS_B;
                o_ctrl.imm       = imm_u;
                o_ctrl.reg_write = 1'b1;
            end
            AUIPC: begin
                o_ctrl.op1_sel   = PC;      // PC + U-immediate
                o_ctrl.imm       = imm_u;
                o_ctrl.reg_write = 1'b1;
            end
            LOAD: begin
                if (funct3 == 3'b010) begin // lw only
                    o_ctrl.op1_sel   = RS1;
                    o_ctrl.imm       = imm_i;
                    o_ctrl.mem_read  = 1'b1;
                    o_ctrl.reg_write = 1'b1;
                end
            end
            STORE: begin
                if (funct3 == 3'b010) begin // sw only
                    o_ctrl.op1_sel   = RS1;
                    o_ctrl.imm       = imm_s;
                    o_ctrl.mem_write = 1'b1;
                end
            end
            BRANCH: begin
                // Compare rs1 with rs2, signedness from funct3[1]
                o_ctrl.alu_op    = funct3[1] ? SLTU : SLT;
                o_ctrl.br_cond   = br_cond_e'(funct3);
                o_ctrl.op1_sel   = RS1;
                o_ctrl.use_imm   = 1'b0;
                o_ctrl.is_branch = 1'b1;
                o_ctrl.imm       = imm_b;   // Target offset, not an operand
            end
            default: ; // Unsupported, retires as a no-op
        endcase
    end

endmodule

//--- hw/reg_file.sv
// 32-entry integer register file, x0 hard-wired to zero
module reg_file import rv_core_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  reg_idx_t i_rs1,
    input  reg_idx_t i_rs2,
    input  reg_idx_t i_rd,
    input  logic     i_wen,
    input  xlen_t    i_wdata,
    output xlen_t    o_rs1_data,
    output xlen_t    o_rs2_data
);

    xlen_t regs [1:31]; // No storage for x0

    ////////////////////////////////////////////////////////////////////
    // Write port, lands at the edge after the read
    ////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n && i_wen && (i_rd != '0)) begin
            regs[i_rd] <= i_wdata;
        end
    end

    // Combinational reads
    assign o_rs1_data = (i_rs1 == '0) ? '0 : regs[i_rs1];
    assign o_rs2_data = (i_rs2 == '0) ? '0 : regs[i_rs2];

endmodule

//--- hw/alu.sv
// Operand select, ALU datapath and branch condition with target
module alu import rv_core_pkg::*; (
    input  ctrl_t i_ctrl,
    input  addr_t i_pc,
    input  xlen_t i_rs1_data,
    input  xlen_t i_rs2_data,
    output xlen_t o_result,
    output logic  o_branch_taken,
    output addr_t o_branch_target
);

    xlen_t      op1;
    xlen_t      op2;
    logic [4:0] shamt;
    logic       eq;
    logic       lt;       // From SLT or SLTU result

    always_comb begin
        case (i_ctrl.op1_sel)
            ZERO:    op1 = '0;    // LUI
            PC:      op1 = i_pc;  // AUIPC
            default: op1 = i_rs1_data;
        endcase
    end

    assign op2   = i_ctrl.use_imm ? i_ctrl.imm : i_rs2_data;
    assign shamt = op2[4:0];

    ////////////////////////////////////////////////////////////////////
    // Datapath
    ////////////////////////////////////////////////////////////////////
    always_comb begin
        case (i_ctrl.alu_op)
            ADD:     o_result = op1 + op2;
            SUB:     o_result = op1 - op2;
            SLL:     o_result = op1 << shamt;
            SLT:     o_result = {31'b0, $signed(op1) < $signed(op2)};
            SLTU:    o_result = {31'b0, op1 < op2};
            XOR:     o_result = op1 ^ op2;
            SRL:     o_result = op1 >> shamt;
            SRA:     o_result = $signed(op1) >>> shamt;
            OR:      o_result = op1 | op2;
            AND:     o_result = op1 & op2;
            PASS_B:  o_result = op2;
            default: o_result = '0;
        endcase
    end

    // Branch compare reuses the SLT/SLTU result chosen by decode
    assign eq = (op1 == op2);
    assign lt = o_result[0];

    always_comb begin
        case (i_ctrl.br_cond)
            BEQ:         o_branch_taken = eq;
            BNE:         o_branch_taken = !eq;
            BLT, BLTU:   o_branch_taken = lt;
            BGE, BGEU:   o_branch_taken = !lt;
            default:     o_branch_taken = 1'b0; // funct3 010/011 never branch
        endcase
        o_branch_taken = o_branch_taken && i_ctrl.is_branch;
    end

    assign o_branch_target = i_pc + i_ctrl.imm; // B-immediate

endmodule

//--- hw/mem_writeback.sv
// Data memory drive, writeback select and retire record assembly
module mem_writeback import rv_core_pkg::*; (
    input  logic    rst_n,
    input  ctrl_t   i_ctrl,
    input  inst_t   i_inst,
    input  addr_t   i_pc,
    input  addr_t   i_next_pc,
    input  xlen_t   i_rs1_data,
    input  xlen_t   i_rs2_data,
    input  xlen_t   i_result,
    input  xlen_t   i_dmem_rdata,
    output addr_t   o_dmem_addr,
    output logic    o_dmem_ren,
    output logic    o_dmem_wen,
    output xlen_t   o_dmem_wdata,
    output xlen_t   o_rd_wdata,
    output retire_t o_retire
);

    logic rs1_used;
    logic rs2_used;

    // Word accesses, address is rs1 + imm from the ALU
    assign o_dmem_addr  = i_result;
    assign o_dmem_wdata = i_rs2_data;
    assign o_dmem_ren   = i_ctrl.mem_read && !rst_n;
    assign o_dmem_wen   = i_ctrl.mem_write && !rst_n;

    assign o_rd_wdata = i_ctrl.mem_read ? i_dmem_rdata : i_result;

    // Which sources the format really reads
    assign rs1_used = (i_ctrl.op1_sel == RS1);                  // Not LUI, AUIPC
    assign rs2_used = !i_ctrl.use_imm || i_ctrl.mem_write;       // R, branch, store

    always_comb begin
        o_retire.valid     = !rst_n;
        o_retire.inst      = i_inst;
        o_retire.pc        = i_pc;
        o_retire.next_pc   = i_next_pc;
        o_retire.rs1_raddr = rs1_used ? i_ctrl.rs1 : '0;
        o_retire.rs2_raddr = rs2_used ? i_ctrl.rs2 : '0;
        o_retire.rs1_rdata = rs1_used ? i_rs1_data : '0;
        o_retire.rs2_rdata = rs2_used ? i_rs2_data : '0;
        o_retire.rd_waddr  = i_ctrl.reg_write ? i_ctrl.rd : '0;
        o_retire.rd_wdata  = o_rd_wdata;
    end

endmodule

//--- hw/rv_core.sv
// Single-cycle RV32I core top, fetch to decode to execute to writeback
module rv_core import rv_core_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    // Instruction port, same-cycle read
    output addr_t   o_imem_raddr,
    input  inst_t   i_imem_rdata,
    // Data port, combinational read and edge write
    output addr_t   o_dmem_addr,
    output logic    o_dmem_ren,
    output logic    o_dmem_wen,
    output xlen_t   o_dmem_wdata,
    input  xlen_t   i_dmem_rdata,
    // One record per instruction
    output retire_t o_retire
);

    ctrl_t ctrl;
    addr_t pc;
    addr_t next_pc;
    xlen_t rs1_data;
    xlen_t rs2_data;
    xlen_t result;       // ALU value or memory address
    logic  branch_taken;
    addr_t branch_target;
    xlen_t rd_wdata;

    ////////////////////////////////////////////////////////////////////
    // Fetch and decode
    ////////////////////////////////////////////////////////////////////
    pc_fetch u_pc_fetch (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_branch_taken  (branch_taken),
        .i_branch_target (branch_target),
        .o_pc            (pc),
        .o_next_pc       (next_pc)
    );

    assign o_imem_raddr = pc;

    inst_decode u_inst_decode (.i_inst(i_imem_rdata), .o_ctrl(ctrl));

    reg_file u_reg_file (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_rs1      (ctrl.rs1),
        .i_rs2      (ctrl.rs2),
        .i_rd       (ctrl.rd),
        .i_wen      (ctrl.reg_write),
        .i_wdata    (rd_wdata),
        .o_rs1_data (rs1_data),
        .o_rs2_data (rs2_data)
    );

    ////////////////////////////////////////////////////////////////////
    // Execute and writeback
    ////////////////////////////////////////////////////////////////////
    alu u_alu (
        .i_ctrl          (ctrl),
        .i_pc            (pc),
        .i_rs1_data      (rs1_data),
        .i_rs2_data      (rs2_data),
        .o_result        (result),
        .o_branch_taken  (branch_taken),
        .o_branch_target (branch_target)
    );

    mem_writeback u_mem_writeback (
        .rst_n        (rst_n),
        .i_ctrl       (ctrl),
        .i_inst       (i_imem_rdata),
        .i_pc         (pc),
        .i_next_pc    (next_pc),
        .i_rs1_data   (rs1_data),
        .i_rs2_data   (rs2_data),
        .i_result     (result),
        .i_dmem_rdata (i_dmem_rdata),
        .o_dmem_addr  (o_dmem_addr),
        .o_dmem_ren   (o_dmem_ren),
        .o_dmem_wen   (o_dmem_wen),
        .o_dmem_wdata (o_dmem_wdata),
        .o_rd_wdata   (rd_wdata),
        .o_retire     (o_retire)
    );

endmodule

//--- tb/rv_core_properties.sv
// Bound checks on reset, ALU writeback, sw and lw, branch next PC, fetch order and x0
module rv_core_properties import rv_core_pkg::*; (
    input logic    clk,
    input logic    rst_n,
    input addr_t   o_imem_raddr,
    input inst_t   i_imem_rdata,
    input addr_t   o_dmem_addr,
    input logic    o_dmem_ren,
    input logic    o_dmem_wen,
    input xlen_t   o_dmem_wdata,
    input xlen_t   i_dmem_rdata,
    input retire_t o_retire
);

    timeunit 1ns;
    timeprecision 1ps;

    logic       fail_seen = 1'b0;  // Polled by the testbench
    logic [6:0] opc;
    logic       is_alu;
    logic       is_sw;
    logic       is_lw;
    logic       is_br;
    xlen_t      exp_wdata;
    addr_t      exp_addr;
    addr_t      exp_next;
    addr_t      imm_b;
    reg_idx_t   exp_rd;        // rd index for formats that write
    reg_idx_t   exp_rs1;       // Zero where the format reads no rs1
    reg_idx_t   exp_rs2;       // Zero where the format reads no rs2
    addr_t      prev_next_pc;  // next_pc of the previous retire
    logic       prev_valid;

    // Reference RV32I result for OP, OP_IMM, LUI and AUIPC
    function automatic xlen_t rv32i_result(input inst_t inst, input xlen_t a,
                                           input xlen_t b, input addr_t pc);
        xlen_t opnd;
        logic  alt;
        alt  = inst[30];
        opnd = (inst[6:0] == OP) ? b : {{20{inst[31]}}, inst[31:20]};
        if (inst[6:0] == LUI) return {inst[31:12], 12'b0};
        if (inst[6:0] == AUIPC) return pc + {inst[31:12], 12'b0};
        case (inst[14:12])
            3'b000:  return (inst[6:0] == OP && alt) ? a - opnd : a + opnd;
            3'b001:  return a << opnd[4:0];
            3'b010:  return ($signed(a) < $signed(opnd)) ? 32'd1 : 32'd0;
            3'b011:  return (a < opnd) ? 32'd1 : 32'd0;
            3'b100:  return a ^ opnd;
            3'b101:  return alt ? xlen_t'($signed(a) >>> opnd[4:0]) : a >> opnd[4:0];
            3'b110:  return a | opnd;
            default: return a & opnd;
        endcase
    endfunction

    function automatic logic branch_holds(input logic [2:0] f3, input xlen_t a, input xlen_t b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            3'b111:  return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    assign opc    = o_retire.inst[6:0];
    assign is_alu = o_retire.valid && (opc == OP || opc == OP_IMM || opc == LUI || opc == AUIPC);
    assign is_sw  = o_retire.valid && (opc == STORE);
    assign is_lw  = o_retire.valid && (opc == LOAD);
    assign is_br  = o_retire.valid && (opc == BRANCH);
    assign imm_b  = {{19{o_retire.inst[31]}}, o_retire.inst[31], o_retire.inst[7],
                     o_retire.inst[30:25], o_retire.inst[11:8], 1'b0};

    // Register indices by format
    assign exp_rd  = (is_alu || is_lw) ? o_retire.inst[11:7] : 5'd0;
    assign exp_rs1 = (opc == OP || opc == OP_IMM || opc == LOAD || opc == STORE
                      || opc == BRANCH) ? o_retire.inst[19:15] : 5'd0;
    assign exp_rs2 = (opc == OP || opc == STORE || opc == BRANCH) ? o_retire.inst[24:20]
                                                                  : 5'd0;

    assign exp_wdata = rv32i_result(o_retire.inst, o_retire.rs1_rdata, o_retire.rs2_rdata,
                                    o_retire.pc);
    assign exp_addr  = o_retire.rs1_rdata + {{20{o_retire.inst[31]}}, o_retire.inst[31:25],
                                             o_retire.inst[11:7]};  // S-immediate
    assign exp_next  = (is_br && branch_holds(o_retire.inst[14:12], o_retire.rs1_rdata,
                                              o_retire.rs2_rdata)) ? o_retire.pc + imm_b
                                                                   : o_retire.pc + 32'd4;

    always_ff @(posedge clk) begin
        if (rst_n) begin
            prev_valid <= 1'b0;
        end else begin
            prev_valid   <= o_retire.valid;
            prev_next_pc <= o_retire.next_pc;
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Checks at mid-cycle, core outputs settled
    ////////////////////////////////////////////////////////////////////
    a_reset_quiet: assert property (@(negedge clk)
        rst_n |-> !o_retire.valid && !o_dmem_wen && !o_dmem_ren)
    else begin
        $error("Retire valid or a dmem enable was high during reset");
        fail_seen = 1'b1;
    end

    a_reset_pc: assert property (@(negedge clk) $fell(rst_n) |-> o_imem_raddr == RESET_ADDR)
    else begin
        $error("MISMATCH %0t o_imem_raddr got %h exp %h", $time, o_imem_raddr, RESET_ADDR);
        fail_seen = 1'b1;
    end

    a_alu: assert property (@(negedge clk) disable iff (rst_n)
        is_alu |-> o_retire.rd_wdata == exp_wdata)
    else begin
        $error("MISMATCH %0t rd_wdata got %h exp %h", $time, o_retire.rd_wdata, exp_wdata);
        fail_seen = 1'b1;
    end

    a_store: assert property (@(negedge clk) disable iff (rst_n)
        is_sw |-> o_dmem_wen && o_dmem_addr == exp_addr && o_dmem_wdata == o_retire.rs2_rdata)
    else begin
        $error("MISMATCH %0t sw o_dmem_wen %b exp 1 o_dmem_addr got %h exp %h wdata got %h exp %h",
               $time, o_dmem_wen, o_dmem_addr, exp_addr, o_dmem_wdata, o_retire.rs2_rdata);
        fail_seen = 1'b1;
    end

    a_load: assert property (@(negedge clk) disable iff (rst_n)
        is_lw |-> o_dmem_ren && o_retire.rd_wdata == i_dmem_rdata)
    else begin
        $error("MISMATCH %0t lw o_dmem_ren %b exp 1 rd_wdata got %h exp %h",
               $time, o_dmem_ren, o_retire.rd_wdata, i_dmem_rdata);
        fail_seen = 1'b1;
    end

    a_next_pc: assert property (@(negedge clk) disable iff (rst_n)
        o_retire.valid |-> o_retire.next_pc == exp_next)
    else begin
        $error("MISMATCH %0t next_pc got %h exp %h", $time, o_retire.next_pc, exp_next);
        fail_seen = 1'b1;
    end

    a_fetch: assert property (@(negedge clk) disable iff (rst_n)
        prev_valid |-> o_imem_raddr == prev_next_pc)
    else begin
        $error("MISMATCH %0t o_imem_raddr got %h exp %h", $time, o_imem_raddr, prev_next_pc);
        fail_seen = 1'b1;
    end

    // Retire record reports the fetched word and its address
    a_retire_src: assert property (@(negedge clk) disable iff (rst_n)
        o_retire.valid |-> o_retire.inst == i_imem_rdata && o_retire.pc == o_imem_raddr
                        && o_retire.rs1_raddr == exp_rs1 && o_retire.rs2_raddr == exp_rs2)
    else begin
        $error("MISMATCH %0t retire inst got %h exp %h pc got %h exp %h rs1 %0d exp %0d rs2 %0d exp %0d",
               $time, o_retire.inst, i_imem_rdata, o_retire.pc, o_imem_raddr,
               o_retire.rs1_raddr, exp_rs1, o_retire.rs2_raddr, exp_rs2);
        fail_seen = 1'b1;
    end

    // rd only where the format writes, x0 reads as zero
    a_reg_zero: assert property (@(negedge clk) disable iff (rst_n)
        o_retire.valid |-> o_retire.rd_waddr == exp_rd
                        && (o_retire.rs1_raddr != 5'd0 || o_retire.rs1_rdata == '0)
                        && (o_retire.rs2_raddr != 5'd0 || o_retire.rs2_rdata == '0))
    else begin
        $error("MISMATCH %0t rd_waddr got %0d exp %0d rs1_rdata got %h rs2_rdata got %h exp 0",
               $time, o_retire.rd_waddr, exp_rd, o_retire.rs1_rdata, o_retire.rs2_rdata);
        fail_seen = 1'b1;
    end

endmodule

//--- tb/tb_rv_core.sv
// Testbench top with clock, reset, imem and dmem models, random program and run control
module tb_rv_core import rv_core_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    logic    clk;
    logic    rst_n;
    addr_t   imem_raddr;
    inst_t   imem_rdata;
    addr_t   dmem_addr;
    logic    dmem_ren;
    logic    dmem_wen;
    xlen_t   dmem_wdata;
    xlen_t   dmem_rdata;
    retire_t retire;

    inst_t       imem [0:63];  // Program, built at time 0
    xlen_t       dmem [0:15];
    logic [31:0] rng_state;

    rv_core dut0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .o_imem_raddr (imem_raddr),
        .i_imem_rdata (imem_rdata),
        .o_dmem_addr  (dmem_addr),
        .o_dmem_ren   (dmem_ren),
        .o_dmem_wen   (dmem_wen),
        .o_dmem_wdata (dmem_wdata),
        .i_dmem_rdata (dmem_rdata),
        .o_retire     (retire)
    );

    bind rv_core rv_core_properties props0 (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;  // 40 ns period
    end

    ////////////////////////////////////////////////////////////////////
    // Memory models, same-cycle reads
    ////////////////////////////////////////////////////////////////////
    assign imem_rdata = imem[imem_raddr[7:2]];
    assign dmem_rdata = dmem[dmem_addr[5:2]];  // Word index, upper bits ignored

    always @(posedge clk) begin
        if (rst_n) begin
            for (int i = 0; i < 16; i++) begin
                dmem[i] <= 32'hDA7A_0000 ^ (i << 2);  // Pattern follows the byte address
            end
        end else if (dmem_wen) begin
            dmem[dmem_addr[5:2]] <= dmem_wdata;
        end
    end

    function automatic logic [31:0] xorshift_next();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // Instruction formats
    function automatic inst_t encode_r(input logic [6:0] f7, input reg_idx_t rs2,
                                       input reg_idx_t rs1, input logic [2:0] f3,
                                       input reg_idx_t rd);
        return {f7, rs2, rs1, f3, rd, OP};
    endfunction

    function automatic inst_t encode_i(input logic [11:0] imm, input reg_idx_t rs1,
                                       input logic [2:0] f3, input reg_idx_t rd,
                                       input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic inst_t encode_s(input logic [11:0] imm, input reg_idx_t rs2,
                                       input reg_idx_t rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], STORE};  // sw
    endfunction

    function automatic inst_t encode_b(input logic [12:0] imm, input reg_idx_t rs2,
                                       input reg_idx_t rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], BRANCH};
    endfunction

    function automatic inst_t encode_u(input logic [19:0] imm, input reg_idx_t rd,
                                       input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    // Kinds 0-2 OP, 3-4 OP_IMM, 5 lui, 6 auipc, 7 sw, 8 lw
    function automatic inst_t random_inst(input int kind);
        logic [31:0] r;
        logic [2:0]  f3;
        logic        alt;
        logic [11:0] imm;
        r   = xorshift_next();
        f3  = r[14:12];
        alt = r[30] && (f3 == 3'b000 || f3 == 3'b101);  // sub and sra only
        imm = r[31:20];
        if (f3 == 3'b001 || f3 == 3'b101) begin
            imm = {1'b0, alt, 5'b0, r[24:20]};  // Legal shamt form
        end
        case (kind)
            0, 1, 2: return encode_r({1'b0, alt, 5'b0}, r[24:20], r[19:15], f3, r[11:7]);
            3, 4:    return encode_i(imm, r[19:15], f3, r[11:7], OP_IMM);
            5:       return encode_u(r[31:12], r[11:7], LUI);
            6:       return encode_u(r[31:12], r[11:7], AUIPC);
            7:       return encode_s({6'b0, r[23:20], 2'b00}, r[11:7], 5'd0);
            default: return encode_i({6'b0, r[23:20], 2'b00}, 5'd0, 3'b010, r[11:7], LOAD);
        endcase
    endfunction

    ////////////////////////////////////////////////////////////////////
    // Program, prologue then body then loop-back branch
    ////////////////////////////////////////////////////////////////////
    initial begin
        logic [31:0] r;
        logic [2:0]  f3;
        int          kind;
        int          b;
        rng_state = 32'h1545;
        for (int n = 0; n < 32; n++) begin
            r = xorshift_next();
            imem[n] = encode_i(r[11:0], 5'd0, 3'b000, 5'(n), OP_IMM);  // addi xN, x0, imm
        end
        kind = 0;
        for (int a = 32; a < 63; a++) begin
            if ((a - 32) % 5 == 0 && a <= 57) begin
                // Forward branch over one word, six conditions in turn
                r  = xorshift_next();
                b  = (a - 32) / 5;
                f3 = (b < 2) ? 3'(b) : 3'(b + 2);
                imem[a] = encode_b(13'd8, r[9:5], r[4:0], f3);
            end else begin
                imem[a] = random_inst(kind % 9);
                kind++;
            end
        end
        imem[63] = encode_b(13'(-252), 5'd0, 5'd0, 3'b000);  // beq x0, x0 to 0
    end

    // Run control
    initial begin
        int cycles;
        rst_n = 1'b1;  // Held for 3 cycles
        repeat (3) @(posedge clk);
        rst_n <= 1'b0;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!retire.valid && cycles < 8);
        if (!retire.valid) begin
            $display(">>> FAIL");
            $fatal(1, "Timed out waiting for the first retired instruction");
        end
        cycles = 0;
        while (cycles < 400 && !dut0.props0.fail_seen) begin
            @(posedge clk);  // Checker flag settles at the negedge before
            cycles++;
        end
        if (dut0.props0.fail_seen) begin
            $display(">>> FAIL");
            $fatal(1, "A bound assertion on the core failed");
        end else begin
            $display(">>> PASS");
            $finish;
        end
    end

endmodule

//--- rv_core.f
hw/rv_core_pkg.sv
hw/pc_fetch.sv
hw/inst_decode.sv
hw/reg_file.sv
hw/alu.sv
hw/mem_writeback.sv
hw/rv_core.sv
tb/rv_core_properties.sv
tb/tb_rv_core.sv

//--- Makefile
TOP := tb_rv_core

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module $(TOP) -f rv_core.f -Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) +verilator+error+limit+100

clean:
	rm -rf obj_dir
